/* rtl/l2_defines.svh */
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes
`define N_REQS          4
`define REQS_BITS       2
`define TAG_BITS        20
`define SET_BITS        6
`define W_OFF_BITS      2
`define B_OFF_BITS      2
`define WORDS_PER_LINE  4
`define WORD_BITS       32
`define LINE_BITS       (`WORDS_PER_LINE * `WORD_BITS)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// buffer operations
`define L2_REQS_IDLE        3'b000
`define L2_REQS_LOOKUP      3'b001
`define L2_REQS_PEEK_REQ    3'b010
`define L2_REQS_PEEK_FLUSH  3'b011 // eviction path only
`define L2_REQS_PEEK_FWD    3'b100

// unstable states, INVALID marks a free entry
`define INVALID 3'b000
`define ISD     3'b001
`define IMAD    3'b010
`define MIA     3'b011

// forwards from the directory
`define FWD_GETS    3'b000
`define FWD_GETM    3'b001
`define FWD_INV     3'b010
`define FWD_INV_LLC 3'b011
`define FWD_PUTACK  3'b100

`endif

/* rtl/l2_pkg.sv */
`include "l2_defines.svh"

package l2_pkg;

    // cpu address, 30 bits
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic [`SET_BITS-1:0]   set;
        logic [`W_OFF_BITS-1:0] w_off;
        logic [`B_OFF_BITS-1:0] b_off;
    } addr_br_t;

    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        logic [`SET_BITS-1:0] set;
    } line_addr_t;

    typedef struct packed {
        logic                  cpu_wr;
        logic [2:0]            hsize;
        addr_br_t              addr;
        logic [`WORD_BITS-1:0] word;
    } cpu_req_t;

    typedef struct packed {
        logic                   cpu_wr;
        logic [`TAG_BITS-1:0]   tag;
        logic [`SET_BITS-1:0]   set;
        logic [2:0]             hsize;
        logic [`W_OFF_BITS-1:0] w_off;
        logic [`B_OFF_BITS-1:0] b_off;
        logic [`WORD_BITS-1:0]  word;
        logic [2:0]             state;
        logic [`LINE_BITS-1:0]  line;
    } reqs_buf_t;

    // one operation on the buffer port
    typedef struct packed {
        logic [2:0]            op;
        logic                  fill;
        logic                  wr_state;
        logic                  wr_line;
        logic                  wr_tag;
        logic                  lookup_en;
        line_addr_t            addr;
        logic [2:0]            fwd_msg;
        cpu_req_t              req;
        logic [2:0]            state;
        logic [`LINE_BITS-1:0] line;
    } reqs_cmd_t;

    typedef struct packed {
        logic [`REQS_BITS-1:0] idx;
        logic                  hit;
        logic                  set_conflict;
        logic                  fwd_stall;
        logic                  fwd_clr;
    } reqs_rsp_t;

    typedef struct packed {
        line_addr_t            addr;
        logic [`LINE_BITS-1:0] line;
    } mem_rsp_t;

endpackage

/* rtl/l2_reqs.sv */
`include "l2_defines.svh"

module l2_reqs (
    input  logic              clk,
    input  logic              rst,
    input  l2_pkg::reqs_cmd_t cmd_i,
    output l2_pkg::reqs_buf_t reqs_o [`N_REQS],
    output l2_pkg::reqs_rsp_t rsp_o
);
    import l2_pkg::*;

    reqs_rsp_t rsp_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry storage, all writes land on the registered index
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `N_REQS; i++) begin
                reqs_o[i].state <= `INVALID; // every entry starts free
            end
        end else begin
            for (int i = 0; i < `N_REQS; i++) begin
                if (rsp_o.idx == `REQS_BITS'(i)) begin
                    if (cmd_i.fill) begin
                        reqs_o[i].cpu_wr <= cmd_i.req.cpu_wr;
                        reqs_o[i].set    <= cmd_i.req.addr.set;
                        reqs_o[i].hsize  <= cmd_i.req.hsize;
                        reqs_o[i].w_off  <= cmd_i.req.addr.w_off;
                        reqs_o[i].b_off  <= cmd_i.req.addr.b_off;
                        reqs_o[i].word   <= cmd_i.req.word;
                    end
                    if (cmd_i.fill || cmd_i.wr_state) begin
                        reqs_o[i].state <= cmd_i.state;
                    end
                    if (cmd_i.fill || cmd_i.wr_line) begin
                        reqs_o[i].line <= cmd_i.line;
                    end
                    // a fill takes the tag from the request, a tag write from the search address
                    if (cmd_i.fill) begin
                        reqs_o[i].tag <= cmd_i.req.addr.tag;
                    end else if (cmd_i.wr_tag) begin
                        reqs_o[i].tag <= cmd_i.addr.tag;
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // searches, the loops leave the highest matching index
    always_comb begin
        rsp_next = '0;
        case (cmd_i.op)
            `L2_REQS_LOOKUP: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (reqs_o[i].state != `INVALID && reqs_o[i].tag == cmd_i.addr.tag &&
                        reqs_o[i].set == cmd_i.addr.set) begin
                        rsp_next.idx = `REQS_BITS'(i);
                        rsp_next.hit = 1'b1;
                    end
                end
            end
            `L2_REQS_PEEK_REQ: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (reqs_o[i].state == `INVALID) begin
                        rsp_next.idx = `REQS_BITS'(i);
                        rsp_next.hit = 1'b1; // here hit means a free entry
                    end
                    if (reqs_o[i].state != `INVALID && reqs_o[i].set == cmd_i.addr.set) begin
                        rsp_next.set_conflict = 1'b1;
                    end
                end
            end
            `L2_REQS_PEEK_FLUSH: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (reqs_o[i].state == `INVALID) begin
                        rsp_next.idx = `REQS_BITS'(i);
                        rsp_next.hit = 1'b1;
                    end
                end
            end
            `L2_REQS_PEEK_FWD: begin
                for (int i = 0; i < `N_REQS; i++) begin
                    if (reqs_o[i].state != `INVALID && reqs_o[i].tag == cmd_i.addr.tag &&
                        reqs_o[i].set == cmd_i.addr.set) begin
                        rsp_next.idx       = `REQS_BITS'(i);
                        rsp_next.hit       = 1'b1;
                        rsp_next.fwd_stall = 1'b0;
                        rsp_next.fwd_clr   = 1'b0;
                        case (cmd_i.fwd_msg)
                            `FWD_PUTACK: begin
                                rsp_next.fwd_clr = 1'b1;
                            end
                            `FWD_INV, `FWD_INV_LLC: begin
                                // only a pending read miss has to hold off an invalidation
                                if (reqs_o[i].state == `ISD) begin
                                    rsp_next.fwd_stall = 1'b1;
                                end else begin
                                    rsp_next.fwd_clr = 1'b1;
                                end
                            end
                            `FWD_GETS, `FWD_GETM: begin
                                if (reqs_o[i].state == `MIA) begin
                                    rsp_next.fwd_clr = 1'b1;
                                end else begin
                                    rsp_next.fwd_stall = 1'b1;
                                end
                            end
                            default: begin
                                rsp_next.fwd_stall = 1'b1; // unknown message waits
                            end
                        endcase
                    end
                end
            end
            default: begin
                rsp_next = '0;
            end
        endcase
    end

    // registered result, held until the next search
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_o <= '0;
        end else if (cmd_i.lookup_en) begin
            rsp_o <= rsp_next;
        end
    end

endmodule

/* rtl/l2_reqs_arbiter.sv */
`include "l2_defines.svh"

module l2_reqs_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  l2_pkg::reqs_cmd_t cpu_cmd_i,
    input  l2_pkg::reqs_cmd_t fwd_cmd_i,
    input  logic              cpu_busy_i,
    input  logic              fwd_busy_i,
    output logic              cpu_gnt_o,
    output logic              fwd_gnt_o,
    output l2_pkg::reqs_cmd_t cmd_o
);
    import l2_pkg::*;

    logic cpu_own_q;

    // the owner keeps the port while busy, otherwise forwards go first
    always_comb begin
        cpu_gnt_o = 1'b0;
        fwd_gnt_o = 1'b0;
        if (cpu_own_q && cpu_busy_i) begin
            cpu_gnt_o = 1'b1;
        end else if (fwd_busy_i) begin
            fwd_gnt_o = 1'b1;
        end else if (cpu_busy_i) begin
            cpu_gnt_o = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cpu_own_q <= 1'b0;
        end else begin
            cpu_own_q <= cpu_gnt_o;
        end
    end

    always_comb begin
        if (cpu_gnt_o) begin
            cmd_o = cpu_cmd_i;
        end else if (fwd_gnt_o) begin
            cmd_o = fwd_cmd_i;
        end else begin
            cmd_o    = '0; // every strobe low
            cmd_o.op = `L2_REQS_IDLE;
        end
    end

endmodule

/* rtl/l2_cpu_req_ctrl.sv */
`include "l2_defines.svh"

module l2_cpu_req_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_req_valid_i,
    input  l2_pkg::cpu_req_t       cpu_req_i,
    input  logic                   mem_rsp_valid_i,
    input  l2_pkg::mem_rsp_t       mem_rsp_i,
    input  logic                   gnt_i,
    input  l2_pkg::reqs_rsp_t      rsp_i,
    input  l2_pkg::reqs_buf_t      reqs_i [`N_REQS],
    output logic                   busy_o,
    output l2_pkg::reqs_cmd_t      cmd_o,
    output logic                   cpu_reject_o,
    output logic                   mem_req_o,
    output l2_pkg::line_addr_t     mem_addr_o,
    output logic                   cpu_done_o,
    output l2_pkg::addr_br_t       cpu_done_addr_o,
    output logic [`LINE_BITS-1:0]  cpu_done_line_o
);
    import l2_pkg::*;

    localparam logic [2:0] C_IDLE   = 3'd0;
    localparam logic [2:0] C_PEEK   = 3'd1; // allocate, search for a free entry
    localparam logic [2:0] C_DECIDE = 3'd2;
    localparam logic [2:0] C_LOOKUP = 3'd3; // retire, find the entry again
    localparam logic [2:0] C_WRITE  = 3'd4;

    logic [2:0] state_q;
    logic       pend_valid_q;
    mem_rsp_t   pend_q;
    mem_rsp_t   cur_q;
    cpu_req_t   req_q;
    logic       take_req;
    logic       take_rsp;
    logic       alloc_ok;

    // a new request wins over a held memory response
    assign take_req = (state_q == C_IDLE) && cpu_req_valid_i;
    assign take_rsp = (state_q == C_IDLE) && !cpu_req_valid_i && pend_valid_q;
    assign alloc_ok = rsp_i.hit && !rsp_i.set_conflict;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q      <= C_IDLE;
            pend_valid_q <= 1'b0;
        end else begin
            if (mem_rsp_valid_i) begin
                pend_valid_q <= 1'b1;
            end else if (take_rsp) begin
                pend_valid_q <= 1'b0;
            end
            case (state_q)
                C_IDLE: begin
                    if (take_req) begin
                        state_q <= C_PEEK;
                    end else if (take_rsp) begin
                        state_q <= C_LOOKUP;
                    end
                end
                C_PEEK:   if (gnt_i) state_q <= C_DECIDE;
                C_DECIDE: state_q <= C_IDLE;
                C_LOOKUP: if (gnt_i) state_q <= C_WRITE;
                default:  state_q <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) req_q <= cpu_req_i;
        if (take_rsp) cur_q <= pend_q;
        if (mem_rsp_valid_i) pend_q <= mem_rsp_i; // one deep
    end

    assign busy_o = (state_q != C_IDLE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cmd_o          = '0;
        cmd_o.op       = `L2_REQS_IDLE;
        cmd_o.req      = req_q;
        cmd_o.addr.tag = req_q.addr.tag;
        cmd_o.addr.set = req_q.addr.set;
        case (state_q)
            C_PEEK: begin
                cmd_o.op        = `L2_REQS_PEEK_REQ;
                cmd_o.lookup_en = 1'b1;
            end
            C_DECIDE: begin
                cmd_o.fill  = alloc_ok;
                cmd_o.state = req_q.cpu_wr ? `IMAD : `ISD;
            end
            C_LOOKUP: begin
                cmd_o.op        = `L2_REQS_LOOKUP;
                cmd_o.lookup_en = 1'b1;
                cmd_o.addr      = cur_q.addr;
            end
            C_WRITE: begin
                cmd_o.wr_state = rsp_i.hit;
                cmd_o.wr_line  = rsp_i.hit;
                cmd_o.state    = `INVALID; // frees the entry
                cmd_o.line     = cur_q.line;
            end
            default: begin
                cmd_o.op = `L2_REQS_IDLE;
            end
        endcase
    end

    assign cpu_reject_o   = (state_q == C_DECIDE) && !alloc_ok;
    assign mem_req_o      = (state_q == C_DECIDE) && alloc_ok;
    assign mem_addr_o.tag = req_q.addr.tag;
    assign mem_addr_o.set = req_q.addr.set;

    // the entry still holds its address during the retiring write
    assign cpu_done_o            = (state_q == C_WRITE) && rsp_i.hit;
    assign cpu_done_addr_o.tag   = reqs_i[rsp_i.idx].tag;
    assign cpu_done_addr_o.set   = reqs_i[rsp_i.idx].set;
    assign cpu_done_addr_o.w_off = reqs_i[rsp_i.idx].w_off;
    assign cpu_done_addr_o.b_off = reqs_i[rsp_i.idx].b_off;
    assign cpu_done_line_o       = cur_q.line;

endmodule

/* rtl/l2_fwd_ctrl.sv */
`include "l2_defines.svh"

module l2_fwd_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               fwd_valid_i,
    input  l2_pkg::line_addr_t fwd_addr_i,
    input  logic [2:0]         fwd_msg_i,
    input  logic               gnt_i,
    input  l2_pkg::reqs_rsp_t  rsp_i,
    output logic               busy_o,
    output l2_pkg::reqs_cmd_t  cmd_o,
    output logic               fwd_done_o,
    output logic               fwd_hit_o,
    output logic               fwd_stall_o,
    output logic               fwd_clr_o
);
    import l2_pkg::*;

    logic       busy_q;
    logic       done_q;
    line_addr_t addr_q;
    logic [2:0] msg_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (!busy_q && fwd_valid_i) begin
                busy_q <= 1'b1;
            end else if (busy_q && gnt_i) begin
                busy_q <= 1'b0; // port is released once the search is issued
            end
            done_q <= busy_q && gnt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && fwd_valid_i) begin
            addr_q <= fwd_addr_i;
            msg_q  <= fwd_msg_i;
        end
    end

    always_comb begin
        cmd_o         = '0;
        cmd_o.op      = `L2_REQS_IDLE;
        cmd_o.addr    = addr_q;
        cmd_o.fwd_msg = msg_q;
        if (busy_q) begin
            cmd_o.op        = `L2_REQS_PEEK_FWD;
            cmd_o.lookup_en = 1'b1;
        end
    end

    assign busy_o = busy_q;

    // buffer result is registered, so it is valid in the done cycle
    assign fwd_done_o  = done_q;
    assign fwd_hit_o   = done_q && rsp_i.hit;
    assign fwd_stall_o = done_q && rsp_i.fwd_stall;
    assign fwd_clr_o   = done_q && rsp_i.fwd_clr;

endmodule

/* rtl/l2_miss_top.sv */
`include "l2_defines.svh"

module l2_miss_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_valid_i,
    input  l2_pkg::cpu_req_t      cpu_req_i,
    input  logic                  mem_rsp_valid_i,
    input  l2_pkg::mem_rsp_t      mem_rsp_i,
    output logic                  cpu_reject_o,
    output logic                  mem_req_o,
    output l2_pkg::line_addr_t    mem_addr_o,
    output logic                  cpu_done_o,
    output l2_pkg::addr_br_t      cpu_done_addr_o,
    output logic [`LINE_BITS-1:0] cpu_done_line_o,
    input  logic                  fwd_valid_i,
    input  l2_pkg::line_addr_t    fwd_addr_i,
    input  logic [2:0]            fwd_msg_i,
    output logic                  fwd_done_o,
    output logic                  fwd_hit_o,
    output logic                  fwd_stall_o,
    output logic                  fwd_clr_o
);

    l2_pkg::reqs_cmd_t cpu_cmd;
    l2_pkg::reqs_cmd_t fwd_cmd;
    l2_pkg::reqs_cmd_t arb_cmd;
    l2_pkg::reqs_rsp_t rsp;
    l2_pkg::reqs_buf_t reqs [`N_REQS];
    logic              cpu_busy;
    logic              fwd_busy;
    logic              cpu_gnt;
    logic              fwd_gnt;

    l2_cpu_req_ctrl u_cpu (
        .clk, .rst, .cpu_req_valid_i, .cpu_req_i, .mem_rsp_valid_i, .mem_rsp_i,
        .gnt_i(cpu_gnt), .rsp_i(rsp), .reqs_i(reqs), .busy_o(cpu_busy), .cmd_o(cpu_cmd),
        .cpu_reject_o, .mem_req_o, .mem_addr_o, .cpu_done_o, .cpu_done_addr_o,
        .cpu_done_line_o
    );

    l2_fwd_ctrl u_fwd (
        .clk, .rst, .fwd_valid_i, .fwd_addr_i, .fwd_msg_i, .gnt_i(fwd_gnt), .rsp_i(rsp),
        .busy_o(fwd_busy), .cmd_o(fwd_cmd), .fwd_done_o, .fwd_hit_o, .fwd_stall_o, .fwd_clr_o
    );

    l2_reqs_arbiter u_arb (
        .clk, .rst, .cpu_cmd_i(cpu_cmd), .fwd_cmd_i(fwd_cmd), .cpu_busy_i(cpu_busy),
        .fwd_busy_i(fwd_busy), .cpu_gnt_o(cpu_gnt), .fwd_gnt_o(fwd_gnt), .cmd_o(arb_cmd)
    );

    l2_reqs u_reqs (.clk, .rst, .cmd_i(arb_cmd), .reqs_o(reqs), .rsp_o(rsp));

endmodule

/* sim/l2_miss_props.sv */
module l2_miss_props (
    input logic clk,
    input logic rst,
    input logic cpu_gnt_i,
    input logic fwd_gnt_i,
    input logic cpu_reject_i,
    input logic mem_req_i,
    input logic cpu_done_i,
    input logic fwd_done_i
);

    int unsigned n_fails = 0;

    a_one_grant: assert property (@(posedge clk) disable iff (!rst) !(cpu_gnt_i && fwd_gnt_i))
        else begin
            $error("both grants of the buffer port are high");
            n_fails++;
        end

    // an allocate decision never ends in both pulses
    a_reject_or_req: assert property (@(posedge clk) disable iff (!rst)
        !(cpu_reject_i && mem_req_i))
        else begin
            $error("reject and memory request pulse in the same cycle");
            n_fails++;
        end

    a_cpu_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        cpu_done_i |=> !cpu_done_i)
        else begin
            $error("cpu done stays high for more than one cycle");
            n_fails++;
        end

    a_fwd_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        fwd_done_i |=> !fwd_done_i)
        else begin
            $error("forward done stays high for more than one cycle");
            n_fails++;
        end

endmodule

bind l2_miss_top l2_miss_props u_props (
    .clk, .rst, .cpu_gnt_i(cpu_gnt), .fwd_gnt_i(fwd_gnt), .cpu_reject_i(cpu_reject_o),
    .mem_req_i(mem_req_o), .cpu_done_i(cpu_done_o), .fwd_done_i(fwd_done_o)
);

/* sim/l2_miss_tb.sv */
`include "l2_defines.svh"

module l2_miss_tb;
    import l2_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  cpu_req_valid;
    cpu_req_t              cpu_req;
    logic                  mem_rsp_valid;
    mem_rsp_t              mem_rsp;
    logic                  fwd_valid;
    line_addr_t            fwd_addr;
    logic [2:0]            fwd_msg;
    logic                  cpu_reject;
    logic                  mem_req;
    line_addr_t            mem_addr;
    logic                  cpu_done;
    addr_br_t              done_addr;
    logic [`LINE_BITS-1:0] done_line;
    logic                  fwd_done;
    logic                  fwd_hit;
    logic                  fwd_stall;
    logic                  fwd_clr;
    integer                seed;

    // reference model with one slot per outstanding miss
    logic                  m_valid [`N_REQS];
    addr_br_t              m_addr  [`N_REQS];
    logic [2:0]            m_state [`N_REQS];

    l2_miss_top u_dut (
        .clk, .rst, .cpu_req_valid_i(cpu_req_valid), .cpu_req_i(cpu_req),
        .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_i(mem_rsp), .cpu_reject_o(cpu_reject),
        .mem_req_o(mem_req), .mem_addr_o(mem_addr), .cpu_done_o(cpu_done),
        .cpu_done_addr_o(done_addr), .cpu_done_line_o(done_line), .fwd_valid_i(fwd_valid),
        .fwd_addr_i(fwd_addr), .fwd_msg_i(fwd_msg), .fwd_done_o(fwd_done), .fwd_hit_o(fwd_hit),
        .fwd_stall_o(fwd_stall), .fwd_clr_o(fwd_clr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [127:0] exp,
                                input logic [127:0] got);
        $display("Fail %s exp %h got %h", name, exp, got);
        abort_run();
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not arrive within 50 cycles", what);
        abort_run();
    endtask

    always @(negedge clk) begin
        if (u_dut.u_props.n_fails != 0) begin
            $display("an assertion on the buffer port or the controller pulses failed");
            abort_run();
        end
    end

    task automatic check_cpu_done(input addr_br_t exp_addr, input addr_br_t got_addr,
                                  input logic [`LINE_BITS-1:0] exp_line,
                                  input logic [`LINE_BITS-1:0] got_line);
        if (got_addr !== exp_addr) report_value("cpu_done_addr_o", exp_addr, got_addr);
        if (got_line !== exp_line) report_value("cpu_done_line_o", exp_line, got_line);
    endtask

    task automatic check_reject(input bit exp, input bit got);
        if (got !== exp) report_value("cpu_reject_o", exp, got);
    endtask

    task automatic check_mem_req(input line_addr_t exp, input line_addr_t got);
        if (got !== exp) report_value("mem_addr_o", exp, got);
    endtask

    // both words are ordered hit, stall, clear
    task automatic check_fwd(input logic [2:0] exp, input logic [2:0] got);
        if (got[2] !== exp[2]) report_value("fwd_hit_o", exp[2], got[2]);
        if (got[1] !== exp[1]) report_value("fwd_stall_o", exp[1], got[1]);
        if (got[0] !== exp[0]) report_value("fwd_clr_o", exp[0], got[0]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic line_addr_t line_of(input addr_br_t a);
        return {a.tag, a.set};
    endfunction

    function automatic int find_valid(input int start);
        int k;
        k = -1;
        for (int i = 0; i < `N_REQS; i++) begin
            if (k < 0 && m_valid[(start + i) % `N_REQS]) k = (start + i) % `N_REQS;
        end
        return k;
    endfunction

    // a PUTACK clears, an invalidation waits only on a pending read and GETS or GETM wait unless MIA
    function automatic logic [2:0] expect_fwd(input line_addr_t a, input logic [2:0] msg);
        int k;
        k = -1;
        for (int i = 0; i < `N_REQS; i++) begin
            if (m_valid[i] && line_of(m_addr[i]) == a) k = i;
        end
        if (k < 0) return 3'b000;
        case (msg)
            `FWD_PUTACK:            return 3'b101;
            `FWD_INV, `FWD_INV_LLC: return (m_state[k] == `ISD) ? 3'b110 : 3'b101;
            default:                return (m_state[k] == `MIA) ? 3'b101 : 3'b110;
        endcase
    endfunction

    function automatic cpu_req_t rand_req();
        logic [95:0] r;
        cpu_req_t    q;
        r = {$random(seed), $random(seed), $random(seed)};
        q = r[$bits(cpu_req_t)-1:0];
        q.addr.tag = q.addr.tag & `TAG_BITS'(3); // few tags and sets so conflicts are common
        q.addr.set = q.addr.set & `SET_BITS'(7);
        return q;
    endfunction

    function automatic logic [2:0] rand_msg();
        logic [31:0] r;
        r = $random(seed);
        return 3'(r % 5);
    endfunction

    function automatic line_addr_t rand_fwd_addr();
        logic [31:0] r;
        line_addr_t  a;
        int          k;
        r = $random(seed);
        k = find_valid(int'(r[1:0]));
        if (r[2] && k >= 0) return line_of(m_addr[k]);
        a          = '0;
        a.tag[1:0] = r[4:3];
        a.set[2:0] = r[7:5];
        return a;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_cpu_req(input cpu_req_t req, input logic with_fwd,
                                input line_addr_t fa, input logic [2:0] fm);
        logic [2:0] exp_fwd;
        logic       exp_rej;
        logic       seen_cpu;
        logic       seen_fwd;
        int         slot;
        exp_fwd = expect_fwd(fa, fm); // the forward wins the port and sees the old entries
        exp_rej = 1'b0;
        slot    = -1;
        for (int i = 0; i < `N_REQS; i++) begin
            if (m_valid[i] && m_addr[i].set == req.addr.set) exp_rej = 1'b1;
            if (!m_valid[i]) slot = i;
        end
        if (slot < 0) exp_rej = 1'b1;
        @(posedge clk);
        #10;
        cpu_req_valid = 1'b1;
        cpu_req       = req;
        fwd_valid     = with_fwd;
        fwd_addr      = fa;
        fwd_msg       = fm;
        @(posedge clk);
        #10;
        cpu_req_valid = 1'b0;
        fwd_valid     = 1'b0;
        seen_cpu      = 1'b0;
        seen_fwd      = !with_fwd;
        for (int n = 0; n < 50 && !(seen_cpu && seen_fwd); n++) begin
            @(negedge clk);
            if (cpu_reject || mem_req) begin
                seen_cpu = 1'b1;
                check_reject(exp_rej, cpu_reject);
                if (!exp_rej) check_mem_req(line_of(req.addr), mem_addr);
            end
            if (fwd_done) begin
                seen_fwd = 1'b1;
                check_fwd(exp_fwd, {fwd_hit, fwd_stall, fwd_clr});
            end
        end
        if (!seen_cpu) report_timeout("CPU reject or memory request");
        if (!seen_fwd) report_timeout("forward done");
        if (!exp_rej) begin
            m_valid[slot] = 1'b1;
            m_addr[slot]  = req.addr;
            m_state[slot] = req.cpu_wr ? `IMAD : `ISD;
        end
    endtask

    task automatic send_mem_rsp(input int k);
        logic [`LINE_BITS-1:0] line;
        logic                  seen;
        line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        @(posedge clk);
        #10;
        mem_rsp_valid = 1'b1;
        mem_rsp.addr  = line_of(m_addr[k]);
        mem_rsp.line  = line;
        @(posedge clk);
        #10;
        mem_rsp_valid = 1'b0;
        seen          = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            @(negedge clk);
            if (cpu_done) begin
                seen = 1'b1;
                check_cpu_done(m_addr[k], done_addr, line, done_line);
            end
        end
        if (!seen) report_timeout("CPU done for the memory response");
        m_valid[k] = 1'b0;
    endtask

    task automatic send_fwd(input line_addr_t fa, input logic [2:0] fm);
        logic [2:0] exp_fwd;
        logic       seen;
        exp_fwd = expect_fwd(fa, fm);
        @(posedge clk);
        #10;
        fwd_valid = 1'b1;
        fwd_addr  = fa;
        fwd_msg   = fm;
        @(posedge clk);
        #10;
        fwd_valid = 1'b0;
        seen      = 1'b0;
        for (int n = 0; n < 50 && !seen; n++) begin
            @(negedge clk);
            if (fwd_done) begin
                seen = 1'b1;
                check_fwd(exp_fwd, {fwd_hit, fwd_stall, fwd_clr});
            end
        end
        if (!seen) report_timeout("forward done");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        cpu_req_t    req;
        logic [31:0] r;
        int          k;
        seed          = 32'h0f068cb3;
        rst           = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        fwd_valid     = 1'b0;
        fwd_addr      = '0;
        fwd_msg       = '0;
        for (int i = 0; i < `N_REQS; i++) m_valid[i] = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b1;

        repeat (4) begin
            @(negedge clk);
            if ({cpu_reject, mem_req, cpu_done, fwd_done} != 4'b0000)
                report_value("cpu_reject_o mem_req_o cpu_done_o fwd_done_o", '0,
                             {cpu_reject, mem_req, cpu_done, fwd_done});
        end

        // four sets fill the buffer, then a fifth set finds it full
        for (int i = 0; i < `N_REQS; i++) begin
            req          = rand_req();
            req.addr.set = i[`SET_BITS-1:0];
            send_cpu_req(req, 1'b0, '0, '0);
        end
        for (int i = 0; i < `N_REQS; i++) send_fwd(line_of(m_addr[i]), rand_msg());
        req          = rand_req();
        req.addr.set = `SET_BITS'(4);
        send_cpu_req(req, 1'b0, '0, '0);
        send_fwd('1, rand_msg()); // no request ever uses this line
        send_mem_rsp(find_valid(0));
        req          = rand_req();
        req.addr.set = m_addr[find_valid(0)].set; // set conflict while one entry is free
        send_cpu_req(req, 1'b0, '0, '0);

        for (int it = 0; it < 300; it++) begin
            r = $random(seed);
            k = find_valid(int'(r[5:4]));
            if (r[1:0] == 2'd2 && k >= 0) begin
                send_mem_rsp(k);
            end else if (r[1:0] == 2'd3) begin
                send_fwd(rand_fwd_addr(), rand_msg());
            end else begin
                send_cpu_req(rand_req(), r[2], rand_fwd_addr(), rand_msg());
            end
        end
        for (k = find_valid(0); k >= 0; k = find_valid(0)) send_mem_rsp(k);

        if (u_dut.u_props.n_fails == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/l2_pkg.sv
rtl/l2_reqs.sv
rtl/l2_reqs_arbiter.sv
rtl/l2_cpu_req_ctrl.sv
rtl/l2_fwd_ctrl.sv
rtl/l2_miss_top.sv
sim/l2_miss_props.sv
sim/l2_miss_tb.sv
